//--- rtwr_params.svh
// Real-time write parameters
`ifndef RTWR_PARAMS_SVH
`define RTWR_PARAMS_SVH

// Register offsets inside the low address nibble
`define REG_STATUS      4'h0        // Status and power control
`define OFF_DAC_CTRL    4'h1        // DAC control, one per channel nibble
`define REG_FVERSION    4'h4        // Firmware version, read only

// Number of DAC channels
// Channels are numbered 1 to NUM_CHANNELS in the upper address nibble
// Values up to 15 fit the nibble
`define NUM_CHANNELS    4

// Value read back from the firmware version register
`define FW_VERSION      32'h5257_0108

// Real-time block mode control, byte address on the AXI side
// Bit 0 of the write data enters (1) or leaves (0) block mode
`define RT_CTRL_ADDR    12'h800

`endif

//--- rtWritePkg.sv
// Real-time write types
package rtWritePkg;

    // Block header quadlet
    // Names the target board and the number of quadlets in its block
    typedef struct packed {
        logic [19:0] rsvd;          // Unused by this board
        logic [3:0]  boardNum;      // Target board strap number
        logic [7:0]  blkLen;        // Block length in quadlets, header included
    } rtHeaderT;

    // DAC control quadlet
    typedef struct packed {
        logic        enable;        // Channel output enable
        logic [14:0] rsvd;          // Not stored
        logic [15:0] dacValue;      // DAC setpoint
    } dacCmdT;

    // One write data word, decoded as header or as DAC command
    // Which view applies depends on where the quadlet sits in the block
    typedef union packed {
        rtHeaderT hdr;
        dacCmdT   dac;
    } quadletU;

endpackage

//--- axiLiteRegPort.sv
// AXI4-Lite register port
`include "rtwr_params.svh"

module axiLiteRegPort import rtWritePkg::*; (
    input  logic        sysclk,
    input  logic        rstN,
    // Write address and data
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    // Write response
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    // Read address and data
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // Register side
    output logic [7:0]  regWaddr,   // Quadlet address
    output quadletU     regWdata,
    output logic        regWen,     // One cycle strobe
    output logic [7:0]  rdAddr,     // Quadlet address for read decode
    input  logic [31:0] rdData,     // Combinational read data
    output logic        blkRtWr     // Real-time block mode
);

    logic wrAccept;                 // Write handshake this cycle
    logic rdAccept;                 // Read handshake this cycle
    logic isRtCtrl;                 // Write targets the mode control address

    // Address and data taken together, one at a time
    assign wrAccept = awvalid & wvalid & ~bvalid;
    assign awready  = wrAccept;
    assign wready   = wrAccept;
    assign isRtCtrl = (awaddr == `RT_CTRL_ADDR);

    // Single outstanding read
    assign rdAccept = arvalid & ~rvalid;
    assign arready  = rdAccept;
    assign rdAddr   = araddr[9:2];  // Byte to quadlet address

    assign bresp = 2'b00;           // Always OKAY
    assign rresp = 2'b00;

    // Write strobe, response and mode flag
    always_ff @(posedge sysclk or negedge rstN) begin
        if (!rstN) begin
            regWen  <= 1'b0;
            bvalid  <= 1'b0;
            blkRtWr <= 1'b0;
        end else begin
            regWen <= wrAccept & ~isRtCtrl;  // Mode writes produce no strobe
            if (wrAccept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wrAccept && isRtCtrl) begin
                blkRtWr <= wdata[0];
            end
        end
    end

    // Write payload, valid with regWen
    always_ff @(posedge sysclk) begin
        if (wrAccept) begin
            regWaddr <= awaddr[9:2];
            regWdata <= wdata;
        end
    end

    // Read response
    always_ff @(posedge sysclk or negedge rstN) begin
        if (!rstN) begin
            rvalid <= 1'b0;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read data captured at acceptance
    always_ff @(posedge sysclk) begin
        if (rdAccept) begin
            rdata <= rdData;
        end
    end

    // Response held until the host takes it
    bvalidHold: assert property (
        @(posedge sysclk) disable iff (!rstN)
        bvalid && !bready |=> bvalid
    );

endmodule

//--- writeAddrTranslate.sv
// Real-time block address translation
`include "rtwr_params.svh"

module writeAddrTranslate import rtWritePkg::*; (
    input  logic       sysclk,
    input  logic       rstN,
    input  logic       blkRtWr,     // Real-time block mode
    input  logic [7:0] regWaddr,    // Quadlet address from host port
    input  logic       regWen,
    input  quadletU    regWdata,    // Header view used here
    input  logic [3:0] boardId,     // Board strap
    output logic [7:0] xlatWaddr,   // Address to register file
    output logic       xlatWen
);

    logic       blkRtWrPrev;        // For rising edge of block mode
    logic [7:0] rtStart;            // Header address of current block
    logic [7:0] rtLen;              // Quadlets in current block
    logic       isLocal;            // Block addressed to this board

    logic       rtRise;
    logic [7:0] nextHdrAddr;        // First quadlet after current block
    logic [7:0] lastAddr;           // Power control quadlet
    logic       isThisHeader;
    logic       isNextHeader;
    logic       isHeader;
    logic       isPowerCtrl;
    logic [3:0] chanNum;            // DAC channel, 1 to N

    assign rtRise       = blkRtWr & ~blkRtWrPrev;
    assign nextHdrAddr  = rtStart + rtLen;
    assign lastAddr     = nextHdrAddr - 8'd1;
    assign isThisHeader = (regWaddr == rtStart);
    assign isNextHeader = (regWaddr == nextHdrAddr);  // Chained block
    assign isHeader     = isThisHeader | isNextHeader;
    assign isPowerCtrl  = (regWaddr == lastAddr);
    assign chanNum      = regWaddr[3:0] - rtStart[3:0];  // Offset from header

    // Block tracking
    always_ff @(posedge sysclk or negedge rstN) begin
        if (!rstN) begin
            blkRtWrPrev <= 1'b0;
            rtStart     <= 8'd0;
            rtLen       <= 8'd0;
            isLocal     <= 1'b0;
        end else begin
            blkRtWrPrev <= blkRtWr;
            if (rtRise) begin
                // New block sequence expects its header at quadlet 0
                rtStart <= 8'd0;
                rtLen   <= 8'd0;
                isLocal <= 1'b0;
            end else if (blkRtWr && regWen && isHeader) begin
                rtStart <= regWaddr;
                rtLen   <= regWdata.hdr.blkLen;
                isLocal <= (regWdata.hdr.boardNum == boardId);
            end
        end
    end

    // Address rewrite
    always_comb begin
        if (!blkRtWr) begin
            xlatWaddr = regWaddr;   // Plain register access
            xlatWen   = regWen;
        end else if (isHeader) begin
            xlatWaddr = {4'd0, `REG_FVERSION};  // Read only target
            xlatWen   = 1'b0;
        end else if (isPowerCtrl) begin
            xlatWaddr = {4'd0, `REG_STATUS};
            xlatWen   = regWen & isLocal;
        end else begin
            xlatWaddr = {chanNum, `OFF_DAC_CTRL};
            xlatWen   = regWen & isLocal;  // Foreign blocks dropped
        end
    end

    // A write that reaches the register file never loads a new header
    noWenOnHeader: assert property (
        @(posedge sysclk) disable iff (!rstN)
        blkRtWr && !rtRise && xlatWen |=> $stable(rtStart) && $stable(rtLen)
    );

endmodule

//--- boardRegFile.sv
// Board register file
`include "rtwr_params.svh"

module boardRegFile import rtWritePkg::*; (
    input  logic        sysclk,
    input  logic        rstN,
    input  logic [7:0]  xlatWaddr,  // Channel nibble and offset
    input  logic        xlatWen,
    input  quadletU     regWdata,   // DAC view used for channel writes
    input  logic [7:0]  rdAddr,
    output logic [31:0] rdData
);

    logic [31:0] statusReg;                     // Power control
    logic        dacEn  [1:`NUM_CHANNELS];      // Per channel enable
    logic [15:0] dacVal [1:`NUM_CHANNELS];      // Per channel setpoint

    logic [3:0] wrChan;
    logic [3:0] wrOff;
    logic       statusWr;
    logic       dacWr;
    logic [3:0] rdChan;
    logic [3:0] rdOff;
    quadletU    rdQ;                            // Read word under assembly

    assign wrChan = xlatWaddr[7:4];
    assign wrOff  = xlatWaddr[3:0];

    // Status lives in the global channel 0
    assign statusWr = xlatWen && (wrChan == 4'd0) && (wrOff == `REG_STATUS);

    // Channels above the populated count are ignored
    assign dacWr = xlatWen && (wrOff == `OFF_DAC_CTRL) && (wrChan != 4'd0)
                   && (wrChan <= 4'(`NUM_CHANNELS));

    always_ff @(posedge sysclk or negedge rstN) begin
        if (!rstN) begin
            statusReg <= 32'd0;
            for (int ch = 1; ch <= `NUM_CHANNELS; ch++) begin
                dacEn[ch]  <= 1'b0;
                dacVal[ch] <= 16'd0;
            end
        end else begin
            if (statusWr) begin
                statusReg <= regWdata;
            end
            for (int ch = 1; ch <= `NUM_CHANNELS; ch++) begin
                if (dacWr && (wrChan == 4'(ch))) begin
                    dacEn[ch]  <= regWdata.dac.enable;
                    dacVal[ch] <= regWdata.dac.dacValue;  // Reserved bits dropped
                end
            end
        end
    end

    assign rdChan = rdAddr[7:4];
    assign rdOff  = rdAddr[3:0];

    // Read decode
    always_comb begin
        rdQ = '0;                                   // Unmapped reads as 0
        if ((rdChan == 4'd0) && (rdOff == `REG_STATUS)) begin
            rdQ = statusReg;
        end else if ((rdChan == 4'd0) && (rdOff == `REG_FVERSION)) begin
            rdQ = `FW_VERSION;
        end else if (rdOff == `OFF_DAC_CTRL) begin
            for (int ch = 1; ch <= `NUM_CHANNELS; ch++) begin
                if (rdChan == 4'(ch)) begin
                    rdQ.dac.enable   = dacEn[ch];
                    rdQ.dac.dacValue = dacVal[ch];
                end
            end
        end
    end

    assign rdData = rdQ;

    // Translated DAC writes stay within the populated channels
    dacChanRange: assert property (
        @(posedge sysclk) disable iff (!rstN)
        xlatWen && (wrOff == `OFF_DAC_CTRL) |-> wrChan <= 4'(`NUM_CHANNELS)
    );

endmodule

//--- rtWriteTop.sv
// Real-time write path top
module rtWriteTop import rtWritePkg::*; (
    input  logic        sysclk,
    input  logic        rstN,
    input  logic [3:0]  boardId,    // Board strap
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic [7:0]  regWaddr;
    quadletU     regWdata;
    logic        regWen;
    logic [7:0]  rdAddr;
    logic [31:0] rdData;
    logic        blkRtWr;
    logic [7:0]  xlatWaddr;
    logic        xlatWen;

    // Host side
    axiLiteRegPort uPort (
        .sysclk  (sysclk),   .rstN    (rstN),
        .awaddr  (awaddr),   .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),    .wvalid  (wvalid),  .wready  (wready),
        .bresp   (bresp),    .bvalid  (bvalid),  .bready  (bready),
        .araddr  (araddr),   .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),    .rresp   (rresp),   .rvalid  (rvalid),
        .rready  (rready),
        .regWaddr(regWaddr), .regWdata(regWdata), .regWen (regWen),
        .rdAddr  (rdAddr),   .rdData  (rdData),   .blkRtWr(blkRtWr)
    );

    // Block write re-targeting
    writeAddrTranslate uXlat (
        .sysclk   (sysclk),   .rstN     (rstN),
        .blkRtWr  (blkRtWr),  .regWaddr (regWaddr),
        .regWen   (regWen),   .regWdata (regWdata),
        .boardId  (boardId),
        .xlatWaddr(xlatWaddr), .xlatWen (xlatWen)
    );

    boardRegFile uRegs (
        .sysclk   (sysclk),    .rstN    (rstN),
        .xlatWaddr(xlatWaddr), .xlatWen (xlatWen),
        .regWdata (regWdata),  .rdAddr  (rdAddr),
        .rdData   (rdData)
    );

endmodule

//--- tbClockGen.sv
// Testbench clock and reset
module tbClockGen (
    output logic sysclk,
    output logic rstN
);

    localparam int HALF_PERIOD = 2;     // Period of 4

    initial begin
        sysclk = 1'b0;
        forever #HALF_PERIOD sysclk = ~sysclk;
    end

    // Reset held for 3 rising edges, released off the edge
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge sysclk);
        #1;
        rstN = 1'b1;
    end

endmodule

//--- rtWriteTb.sv
// Real-time write path testbench
`include "rtwr_params.svh"

module rtWriteTb;

    localparam logic [3:0] BOARD_ID = 4'd3;         // Strap of the board under test
    localparam logic [3:0] OTHER_ID = 4'd5;         // Some other board on the bus
    localparam int BLK_LEN  = `NUM_CHANNELS + 2;    // Header, DAC quadlets, power
    localparam int NUM_TESTS = 5;
    localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS;
    localparam int HS_LIMIT = 16;                   // Cycles allowed per handshake

    logic        sysclk;
    logic        rstN;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] refRegs [0:255];   // Expected read value per quadlet address
    logic [31:0] rngState;
    logic [31:0] wrData;            // Random write value of a single access
    string       testName;
    int          testErrs;
    int          errCount;
    int          checkCount;
    int          testCount;

    tbClockGen uClk (.sysclk(sysclk), .rstN(rstN));

    rtWriteTop DUT (
        .sysclk (sysclk),  .rstN   (rstN),    .boardId(BOARD_ID),
        .awaddr (awaddr),  .awvalid(awvalid), .awready(awready),
        .wdata  (wdata),   .wvalid (wvalid),  .wready (wready),
        .bresp  (bresp),   .bvalid (bvalid),  .bready (bready),
        .araddr (araddr),  .arvalid(arvalid), .arready(arready),
        .rdata  (rdata),   .rresp  (rresp),   .rvalid (rvalid),
        .rready (rready)
    );

    function automatic logic [31:0] xorshift32();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [11:0] dacByteAddr(input int ch);
        return {2'b00, 4'(ch), `OFF_DAC_CTRL, 2'b00};  // Channel nibble, offset, byte lanes
    endfunction

    function automatic logic [11:0] quadByteAddr(input logic [7:0] q);
        return {2'b00, q, 2'b00};
    endfunction

    // Reference register behavior
    task automatic modelStore(input logic [7:0] qaddr, input logic [31:0] data);
        if (qaddr == {4'd0, `REG_STATUS}) begin
            refRegs[qaddr] = data;                      // Status keeps the whole word
        end else if ((qaddr[3:0] == `OFF_DAC_CTRL) && (qaddr[7:4] != 4'd0)
                     && (qaddr[7:4] <= 4'(`NUM_CHANNELS))) begin
            refRegs[qaddr] = {data[31], 15'd0, data[15:0]};  // Enable and setpoint only
        end
        // Firmware version and unmapped quadlets never change
    endtask

    task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data);
        int   stall;
        int   waitCyc;
        logic seen;
        stall = int'(xorshift32() & 32'd3);             // bready held off 0 to 3 cycles
        @(posedge sysclk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waitCyc = 0;
        do begin
            @(negedge sysclk);
            seen = awready & wready;                    // Handshake at the coming edge
            @(posedge sysclk);
            waitCyc++;
        end while (!seen && waitCyc < HS_LIMIT);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!seen) begin
            $display("Write to address %h was never accepted", addr);
            errCount++;
            testErrs++;
        end else begin
            repeat (stall) begin
                @(posedge sysclk);
                #1;
            end
            bready  = 1'b1;
            waitCyc = 0;
            do begin
                @(negedge sysclk);
                seen = bvalid;
                @(posedge sysclk);
                waitCyc++;
            end while (!seen && waitCyc < HS_LIMIT);
            #1;
            bready = 1'b0;
            if (!seen) begin
                $display("No write response for address %h", addr);
                errCount++;
                testErrs++;
            end
        end
    endtask

    task automatic axiRead(input logic [11:0] addr, output logic [31:0] data);
        int   stall;
        int   waitCyc;
        logic seen;
        stall = int'(xorshift32() & 32'd3);             // rready held off 0 to 3 cycles
        data  = 'x;
        @(posedge sysclk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        waitCyc = 0;
        do begin
            @(negedge sysclk);
            seen = arready;
            @(posedge sysclk);
            waitCyc++;
        end while (!seen && waitCyc < HS_LIMIT);
        #1;
        arvalid = 1'b0;
        if (!seen) begin
            $display("Read of address %h was never accepted", addr);
            errCount++;
            testErrs++;
        end else begin
            repeat (stall) begin
                @(posedge sysclk);
                #1;
            end
            rready  = 1'b1;
            waitCyc = 0;
            do begin
                @(negedge sysclk);
                seen = rvalid;
                data = rdata;                           // Stable mid cycle
                @(posedge sysclk);
                waitCyc++;
            end while (!seen && waitCyc < HS_LIMIT);
            #1;
            rready = 1'b0;
            if (!seen) begin
                $display("No read data for address %h", addr);
                errCount++;
                testErrs++;
            end
        end
    endtask

    task automatic checkRead(input logic [11:0] addr, input logic [31:0] expVal);
        logic [31:0] got;
        axiRead(addr, got);
        checkCount++;
        readMatch: assert (got === expVal) else begin
            $display("[ERROR] %s addr %h expected %h actual %h", testName, addr, expVal, got);
            errCount++;
            testErrs++;
        end
    endtask

    task automatic checkAll();
        for (int ch = 1; ch <= `NUM_CHANNELS; ch++) begin
            checkRead(dacByteAddr(ch), refRegs[{4'(ch), `OFF_DAC_CTRL}]);
        end
        checkRead(12'h000, refRegs[{4'd0, `REG_STATUS}]);
    endtask

    task automatic setRtMode(input logic on);
        axiWrite(`RT_CTRL_ADDR, {31'd0, on});
    endtask

    // One block of header, DAC quadlets and power quadlet from quadlet start
    task automatic rtBlock(input logic [7:0] start, input logic [3:0] board);
        logic [31:0] data;
        logic [7:0]  q;
        axiWrite(quadByteAddr(start), {20'd0, board, 8'(BLK_LEN)});
        for (int i = 1; i < BLK_LEN; i++) begin
            data = xorshift32();
            q    = start + 8'(i);
            axiWrite(quadByteAddr(q), data);
            if (board == BOARD_ID) begin
                if (i == BLK_LEN - 1) begin
                    modelStore({4'd0, `REG_STATUS}, data);  // Last quadlet is power
                end else begin
                    modelStore({4'(i), `OFF_DAC_CTRL}, data);
                end
            end
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrs = 0;
    endtask

    task automatic endTest();
        testCount++;
        $display("%s finished with %0d errors", testName, testErrs);
    endtask

    // Responses stay up until taken, read data frozen meanwhile
    bvalidHeld: assert property (@(posedge sysclk) disable iff (!rstN)
        bvalid && !bready |=> bvalid)
        else begin
            $display("bvalid dropped before bready was seen");
            errCount++;
        end

    rvalidHeld: assert property (@(posedge sysclk) disable iff (!rstN)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $display("rvalid dropped or rdata changed before rready was seen");
            errCount++;
        end

    // Every response is OKAY
    brespOkay: assert property (@(posedge sysclk) disable iff (!rstN)
        bvalid |-> bresp == 2'b00)
        else begin
            $display("[ERROR] %s bresp expected %h actual %h", testName, 2'b00, bresp);
            errCount++;
            testErrs++;
        end

    rrespOkay: assert property (@(posedge sysclk) disable iff (!rstN)
        rvalid |-> rresp == 2'b00)
        else begin
            $display("[ERROR] %s rresp expected %h actual %h", testName, 2'b00, rresp);
            errCount++;
            testErrs++;
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        rngState   = 32'h950f;
        wrData     = '0;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        for (int i = 0; i < 256; i++) begin
            refRegs[8'(i)] = '0;                        // All registers clear after reset
        end
        refRegs[{4'd0, `REG_FVERSION}] = `FW_VERSION;
        wait (rstN === 1'b1);

        startTest("plainRw");
        checkAll();                                     // Reset values
        for (int ch = 1; ch <= `NUM_CHANNELS; ch++) begin
            wrData = xorshift32();
            axiWrite(dacByteAddr(ch), wrData);
            modelStore({4'(ch), `OFF_DAC_CTRL}, wrData);
        end
        wrData = xorshift32();
        axiWrite(12'h000, wrData);
        modelStore({4'd0, `REG_STATUS}, wrData);
        checkAll();
        endTest();

        startTest("localBlock");
        setRtMode(1'b1);
        rtBlock(8'd0, BOARD_ID);
        setRtMode(1'b0);
        checkAll();
        endTest();

        startTest("foreignBlock");
        setRtMode(1'b1);
        rtBlock(8'd0, OTHER_ID);                        // Nothing should land
        setRtMode(1'b0);
        checkAll();
        endTest();

        startTest("chainedBlocks");
        setRtMode(1'b1);
        rtBlock(8'd0, OTHER_ID);
        rtBlock(8'(BLK_LEN), BOARD_ID);                 // Header right after the first block
        setRtMode(1'b0);
        checkAll();
        endTest();

        startTest("fwVersion");
        checkRead(quadByteAddr({4'd0, `REG_FVERSION}), refRegs[{4'd0, `REG_FVERSION}]);
        wrData = xorshift32();
        axiWrite(quadByteAddr({4'd0, `REG_FVERSION}), wrData);
        modelStore({4'd0, `REG_FVERSION}, wrData);      // Read only
        checkRead(quadByteAddr({4'd0, `REG_FVERSION}), refRegs[{4'd0, `REG_FVERSION}]);
        endTest();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
rtWritePkg.sv
axiLiteRegPort.sv
writeAddrTranslate.sv
boardRegFile.sv
rtWriteTop.sv
tbClockGen.sv
rtWriteTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rtWriteTb -f verilog.f -o rtWriteSim \
    && ./obj_dir/rtWriteSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || grep -q "TEST PASS" sim.log
